// File: logic/oled_pkg.sv
package oled_pkg;

    localparam int PANEL_W = 96;
    localparam int PANEL_H = 64;
    localparam int PIXELS  = PANEL_W * PANEL_H;

    localparam int RESET_LOW_CYCLES  = 40;
    localparam int RESET_WAIT_CYCLES = 40;

    localparam int BYTE_CYCLES = 17; // 16 clocking cycles and one with csn high.

    // column range 0..95, then row range 0..63.
    localparam logic [7:0] WIN_CMDS [6] = '{8'h15, 8'h00, 8'd95, 8'h75, 8'h00, 8'd63};

    localparam int INIT_LEN = 18;

    typedef enum logic [2:0] {
        RST_LOW,
        RST_WAIT,
        INIT,
        WINDOW,
        PIXEL,
        DELAY
    } ctrl_state_e;

    typedef enum logic [1:0] {
        OP_CMD,   // byte with dc low.
        OP_DELAY, // 256 cycle pause.
        OP_END
    } init_op_e;

endpackage

// File: logic/hex_pkg.sv
package hex_pkg;

    localparam int CELL_W = 6;
    localparam int CELL_H = 8;

    localparam int DIGITS_PER_ROW = 16;
    localparam int TEXT_ROWS      = 2;

    // RGB332 colors.
    localparam logic [7:0] FG_EVEN = 8'hFC; // yellow.
    localparam logic [7:0] FG_ODD  = 8'h1F; // cyan.
    localparam logic [7:0] BG      = 8'h00;

endpackage

// File: logic/oled_init_rom.sv
`timescale 1ns/10ps

module oled_init_rom (
    input  logic [4:0]         init_addr,
    output oled_pkg::init_op_e init_op,
    output logic [7:0]         init_data
);
    import oled_pkg::*;

    logic [9:0] entry; // op in the top two bits.

    // start line 0 and normal display mode are panel defaults after resn.
    always_comb
    begin
        case (init_addr)
            5'd0:    entry = {OP_CMD, 8'hAE};   // display off.
            5'd1:    entry = {OP_CMD, 8'hA0};   // remap.
            5'd2:    entry = {OP_CMD, 8'h22};   // x flip, 256 colors.
            5'd3:    entry = {OP_CMD, 8'hA2};   // display offset.
            5'd4:    entry = {OP_CMD, 8'h00};
            5'd5:    entry = {OP_CMD, 8'hA8};   // multiplex ratio.
            5'd6:    entry = {OP_CMD, 8'h3F};
            5'd7:    entry = {OP_CMD, 8'hAD};   // master config.
            5'd8:    entry = {OP_CMD, 8'h8E};   // external vcc.
            5'd9:    entry = {OP_DELAY, 8'h00};
            5'd10:   entry = {OP_CMD, 8'h81};   // contrast A.
            5'd11:   entry = {OP_CMD, 8'h80};
            5'd12:   entry = {OP_CMD, 8'h82};   // contrast B.
            5'd13:   entry = {OP_CMD, 8'h80};
            5'd14:   entry = {OP_CMD, 8'h83};   // contrast C.
            5'd15:   entry = {OP_CMD, 8'h80};
            5'd16:   entry = {OP_CMD, 8'h87};   // master current.
            5'd17:   entry = {OP_CMD, 8'h06};
            5'd18:   entry = {OP_DELAY, 8'h00};
            5'd19:   entry = {OP_CMD, 8'hAF};   // display on.
            default: entry = {OP_END, 8'h00};
        endcase
    end

    assign init_op   = init_op_e'(entry[9:8]);
    assign init_data = entry[7:0];

endmodule

// File: logic/spi_byte_tx.sv
`timescale 1ns/10ps

module spi_byte_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       tx_dc,
    output logic       csn,
    output logic       sclk,
    output logic       mosi,
    output logic       dc,
    output logic       tx_done
);
    import oled_pkg::*;

    logic       active;
    logic [4:0] phase;
    logic [7:0] shreg;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active <= 1'b0;
            phase  <= 5'd0;
            shreg  <= 8'h00;
            dc     <= 1'b0;
        end
        else if (tx_start)
        begin
            active <= 1'b1;
            phase  <= 5'd0;
            shreg  <= tx_byte;
            dc     <= tx_dc;
        end
        else if (active)
        begin
            phase <= phase + 5'd1;
            if (tx_done)
                active <= 1'b0;
            if (!phase[4] && phase[0])
                shreg <= {shreg[6:0], 1'b0}; // next bit on the falling edge.
        end
    end

    assign csn     = !active || phase[4];
    assign sclk    = active && !phase[4] && phase[0];
    assign mosi    = shreg[7];
    assign tx_done = active && (phase == 5'(BYTE_CYCLES - 1));

endmodule

// File: logic/hex_renderer.sv
`timescale 1ns/10ps

module hex_renderer (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         px_req,
    input  logic [6:0]   px_x,
    input  logic [5:0]   px_y,
    input  logic [127:0] frame_word,
    output logic [7:0]   px_color
);
    import hex_pkg::*;

    logic [3:0]  cell_col;
    logic [2:0]  cell_x;
    logic [2:0]  text_row;
    logic [2:0]  cell_y;
    logic [3:0]  nib_idx;
    logic [63:0] half;
    logic [3:0]  nib;
    logic [34:0] glyph;
    logic [5:0]  bit_idx;
    logic        glyph_bit;

    // 5x7 glyphs, top row in the high bits, leftmost column first.
    function automatic logic [34:0] font(input logic [3:0] digit);
        case (digit)
            4'h0:    font = {5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E};
            4'h1:    font = {5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E};
            4'h2:    font = {5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F};
            4'h3:    font = {5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E};
            4'h4:    font = {5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02};
            4'h5:    font = {5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E};
            4'h6:    font = {5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E};
            4'h7:    font = {5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08};
            4'h8:    font = {5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E};
            4'h9:    font = {5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C};
            4'hA:    font = {5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11};
            4'hB:    font = {5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E};
            4'hC:    font = {5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E};
            4'hD:    font = {5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C};
            4'hE:    font = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F};
            default: font = {5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10};
        endcase
    endfunction

    always_comb
    begin
        cell_col = 4'(px_x / CELL_W);
        cell_x   = 3'(px_x % CELL_W);
        text_row = 3'(px_y / CELL_H);
        cell_y   = 3'(px_y % CELL_H);

        half    = text_row[0] ? frame_word[127:64] : frame_word[63:0];
        nib_idx = 4'(DIGITS_PER_ROW - 1) - cell_col; // digit 0 is the top nibble.
        nib     = half[{nib_idx, 2'b00} +: 4];

        glyph   = font(nib);
        bit_idx = 6'd34 - (6'(cell_y) * 6'd5 + 6'(cell_x));

        // spacing column, spacing row and rows without text stay dark.
        if (cell_x < 3'd5 && cell_y < 3'd7 && text_row < 3'(TEXT_ROWS))
            glyph_bit = glyph[bit_idx];
        else
            glyph_bit = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            px_color <= BG;
        else if (px_req)
            px_color <= glyph_bit ? (cell_col[0] ? FG_ODD : FG_EVEN) : BG;
    end

endmodule

// File: logic/oled_controller.sv
`timescale 1ns/10ps

module oled_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tx_done,
    input  oled_pkg::init_op_e init_op,
    input  logic [7:0]         init_data,
    output logic               resn,
    output logic               tx_start,
    output logic [7:0]         tx_byte,
    output logic               tx_dc,
    output logic [4:0]         init_addr,
    output logic               px_req,
    output logic [6:0]         px_x,
    output logic [5:0]         px_y,
    output logic               frame_start
);
    import oled_pkg::*;

    ctrl_state_e state;
    logic [7:0]  cnt;     // shared by reset timing and init pauses.
    logic [2:0]  win_idx;
    logic        busy;    // a byte is on the wire.
    logic        px_pend; // color arrives this cycle.
    logic        go;

    always_comb
    begin
        go          = !busy || tx_done;
        tx_start    = 1'b0;
        tx_byte     = 8'h00; // pixel bytes come from the renderer.
        tx_dc       = 1'b0;
        px_req      = 1'b0;
        frame_start = 1'b0;
        case (state)
            INIT:
                if (go)
                begin
                    if (init_op == OP_CMD)
                    begin
                        tx_start = 1'b1;
                        tx_byte  = init_data;
                    end
                    else if (init_op == OP_END)
                        frame_start = 1'b1;
                end
            WINDOW:
                if (go)
                begin
                    if (win_idx < 3'd6)
                    begin
                        tx_start = 1'b1;
                        tx_byte  = WIN_CMDS[win_idx];
                    end
                    else
                        px_req = 1'b1;
                end
            PIXEL:
            begin
                tx_dc = 1'b1;
                if (px_pend)
                    tx_start = 1'b1;
                else if (tx_done)
                begin
                    if (px_x == 7'd0 && px_y == 6'd0)
                        frame_start = 1'b1; // counters wrapped, frame complete.
                    else
                        px_req = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= RST_LOW;
            cnt       <= 8'd0;
            resn      <= 1'b0;
            init_addr <= 5'd0;
            win_idx   <= 3'd0;
            busy      <= 1'b0;
            px_pend   <= 1'b0;
            px_x      <= 7'd0;
            px_y      <= 6'd0;
        end
        else
        begin
            if (tx_start)
                busy <= 1'b1;
            else if (tx_done)
                busy <= 1'b0;
            px_pend <= px_req;

            case (state)
                RST_LOW:
                    if (cnt == 8'(RESET_LOW_CYCLES - 1))
                    begin
                        cnt   <= 8'd0;
                        resn  <= 1'b1;
                        state <= RST_WAIT;
                    end
                    else
                        cnt <= cnt + 8'd1;
                RST_WAIT:
                    if (cnt == 8'(RESET_WAIT_CYCLES - 1))
                    begin
                        cnt   <= 8'd0;
                        state <= INIT;
                    end
                    else
                        cnt <= cnt + 8'd1;
                INIT:
                    if (tx_start)
                        init_addr <= init_addr + 5'd1;
                    else if (go && init_op == OP_DELAY)
                    begin
                        init_addr <= init_addr + 5'd1;
                        cnt       <= 8'd0;
                        state     <= DELAY;
                    end
                    else if (frame_start)
                    begin
                        win_idx <= 3'd0;
                        state   <= WINDOW;
                    end
                DELAY:
                begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'hFF)
                        state <= INIT;
                end
                WINDOW:
                    if (tx_start)
                        win_idx <= win_idx + 3'd1;
                    else if (px_req)
                        state <= PIXEL;
                PIXEL:
                    if (px_pend)
                    begin
                        if (px_x == 7'(PANEL_W - 1))
                        begin
                            px_x <= 7'd0;
                            px_y <= (px_y == 6'(PANEL_H - 1)) ? 6'd0 : px_y + 6'd1;
                        end
                        else
                            px_x <= px_x + 7'd1;
                    end
                    else if (frame_start)
                    begin
                        win_idx <= 3'd0;
                        state   <= WINDOW;
                    end
                default:
                    state <= RST_LOW;
            endcase
        end
    end

endmodule

// File: logic/hex_display_top.sv
`timescale 1ns/10ps

module hex_display_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [6:0] btn,
    output logic       oled_csn,
    output logic       oled_clk,
    output logic       oled_mosi,
    output logic       oled_dc,
    output logic       oled_resn
);
    import oled_pkg::*;

    init_op_e     init_op;
    logic [7:0]   init_data;
    logic [4:0]   init_addr;
    logic         tx_start;
    logic [7:0]   cmd_byte;
    logic [7:0]   spi_byte;
    logic         tx_dc;
    logic         tx_done;
    logic         px_req;
    logic [6:0]   px_x;
    logic [5:0]   px_y;
    logic [7:0]   px_color;
    logic         frame_start;
    logic [63:0]  frame_cnt;
    logic [63:0]  next_cnt;
    logic [63:0]  btn_word;
    logic [127:0] frame_word;

    always_comb
    begin
        btn_word = 64'd0;
        for (int i = 0; i < 7; i++)
            btn_word[i * 4] = btn[i]; // one button per nibble.
    end

    assign next_cnt = frame_cnt + 64'd1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            frame_cnt <= 64'd0;
        else if (frame_start)
            frame_cnt <= next_cnt;
    end

    // held for the whole frame.
    always_ff @(posedge clk)
    begin
        if (frame_start)
            frame_word <= {next_cnt, btn_word};
    end

    assign spi_byte = tx_dc ? px_color : cmd_byte;

    oled_controller u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_done     (tx_done),
        .init_op     (init_op),
        .init_data   (init_data),
        .resn        (oled_resn),
        .tx_start    (tx_start),
        .tx_byte     (cmd_byte),
        .tx_dc       (tx_dc),
        .init_addr   (init_addr),
        .px_req      (px_req),
        .px_x        (px_x),
        .px_y        (px_y),
        .frame_start (frame_start)
    );

    oled_init_rom u_rom (
        .init_addr (init_addr),
        .init_op   (init_op),
        .init_data (init_data)
    );

    hex_renderer u_render (
        .clk        (clk),
        .rst_n      (rst_n),
        .px_req     (px_req),
        .px_x       (px_x),
        .px_y       (px_y),
        .frame_word (frame_word),
        .px_color   (px_color)
    );

    spi_byte_tx u_spi (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (spi_byte),
        .tx_dc    (tx_dc),
        .csn      (oled_csn),
        .sclk     (oled_clk),
        .mosi     (oled_mosi),
        .dc       (oled_dc),
        .tx_done  (tx_done)
    );

endmodule

// File: bench/oled_panel_model.sv
`timescale 1ns/10ps

module oled_panel_model (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       csn,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       dc,
    output logic       byte_stb,
    output logic [7:0] byte_data,
    output logic       byte_dc,
    output logic       byte_init,
    output int         byte_idx
);
    import oled_pkg::*;

    logic       sclk_q;
    logic [7:0] shreg;
    logic       seen_pix;
    logic       last_pix;
    int         bit_cnt;
    int         init_cnt;
    int         win_cnt;
    int         pix_cnt;

    // pins settle after the rising system clock, so a rising oled_clk is found on the falling one.
    always @(negedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sclk_q    <= 1'b0;
            shreg     <= 8'h00;
            seen_pix  <= 1'b0;
            last_pix  <= 1'b0;
            bit_cnt   <= 0;
            init_cnt  <= 0;
            win_cnt   <= 0;
            pix_cnt   <= 0;
            byte_stb  <= 1'b0;
            byte_data <= 8'h00;
            byte_dc   <= 1'b0;
            byte_init <= 1'b0;
            byte_idx  <= 0;
        end
        else
        begin
            sclk_q   <= sclk;
            byte_stb <= 1'b0;
            if (csn)
                bit_cnt <= 0;
            else if (sclk && !sclk_q)
            begin
                shreg <= {shreg[6:0], mosi};
                if (bit_cnt == 7)
                begin
                    bit_cnt   <= 0;
                    byte_stb  <= 1'b1;
                    byte_data <= {shreg[6:0], mosi};
                    byte_dc   <= dc;
                    if (dc)
                    begin
                        byte_init <= 1'b0;
                        byte_idx  <= last_pix ? pix_cnt : 0;
                        pix_cnt   <= last_pix ? pix_cnt + 1 : 1;
                        last_pix  <= 1'b1;
                        seen_pix  <= 1'b1;
                    end
                    else if (!seen_pix && init_cnt < INIT_LEN)
                    begin
                        byte_init <= 1'b1; // command bytes before the first window.
                        byte_idx  <= init_cnt;
                        init_cnt  <= init_cnt + 1;
                    end
                    else
                    begin
                        byte_init <= 1'b0;
                        byte_idx  <= last_pix ? 0 : win_cnt;
                        win_cnt   <= last_pix ? 1 : win_cnt + 1;
                        last_pix  <= 1'b0;
                    end
                end
                else
                    bit_cnt <= bit_cnt + 1;
            end
        end
    end

endmodule

// File: bench/tb_hex_display.sv
`timescale 1ns/10ps

module tb_hex_display;
    import oled_pkg::*;
    import hex_pkg::*;

    localparam int FRAME_CYCLES = 6 * BYTE_CYCLES + PIXELS * (BYTE_CYCLES + 1) + 1;
    localparam int CYCLE_LIMIT  = 4 * FRAME_CYCLES + 2000;
    localparam int FRAMES       = 3;
    localparam int BTN_PIXEL    = 3000;

    // classic 5x7 hex font, one row per entry, leftmost column in bit 4.
    localparam logic [4:0] GLYPH [16][7] = '{
        '{5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110},
        '{5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110},
        '{5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111},
        '{5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110},
        '{5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010},
        '{5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110},
        '{5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110},
        '{5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000},
        '{5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110},
        '{5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100},
        '{5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001},
        '{5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10001, 5'b10001, 5'b11110},
        '{5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000, 5'b10001, 5'b01110},
        '{5'b11100, 5'b10010, 5'b10001, 5'b10001, 5'b10001, 5'b10010, 5'b11100},
        '{5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111},
        '{5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b10000}
    };

    logic         clk;
    logic         rst_n;
    logic [6:0]   btn;
    logic         oled_csn;
    logic         oled_clk;
    logic         oled_mosi;
    logic         oled_dc;
    logic         oled_resn;
    logic         byte_stb;
    logic [7:0]   byte_data;
    logic         byte_dc;
    logic         byte_init;
    int           byte_idx;

    int           cycles      = 0;
    int           test_errs   = 0;
    int           err_total   = 0;
    int           pass_cnt    = 0;
    int           fail_cnt    = 0;
    int           init_seen   = 0;
    int           win_seen    = 0;
    int           pix_seen    = 0;
    int           frame_num   = 0;
    int           frames_done = 0;
    int           low_cycles  = 0;
    logic         test_open   = 1'b0;
    logic         init_done   = 1'b0;
    logic         pix_open    = 1'b0;
    logic         btn_due     = 1'b0;
    logic [6:0]   rec_btn;
    logic [127:0] exp_word;
    string        test_name;

    hex_display_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn       (btn),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    oled_panel_model panel (
        .clk       (clk),
        .rst_n     (rst_n),
        .csn       (oled_csn),
        .sclk      (oled_clk),
        .mosi      (oled_mosi),
        .dc        (oled_dc),
        .byte_stb  (byte_stb),
        .byte_data (byte_data),
        .byte_dc   (byte_dc),
        .byte_init (byte_init),
        .byte_idx  (byte_idx)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("ERROR: timeout after %0d cycles with %0d frames checked",
                     cycles, frames_done);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [127:0] build_word(input int frame, input logic [6:0] buttons);
        logic [127:0] word;
        int           i;
        word          = '0;
        word[127:64]  = 64'(frame);
        for (i = 0; i < 7; i++)
            word[7'(4 * i)] = buttons[i]; // lowest bit of nibbles 0 to 6.
        return word;
    endfunction

    function automatic logic [7:0] expect_color(input int x, input int y, input logic [127:0] word);
        int         col;
        int         cx;
        int         row;
        int         cy;
        logic [3:0] nib;
        logic [4:0] line;
        col = x / CELL_W;
        cx  = x % CELL_W;
        row = y / CELL_H;
        cy  = y % CELL_H;
        if (row >= TEXT_ROWS || cx >= 5 || cy >= 7)
            return BG;
        // left digit is the top nibble.
        nib  = word[7'(row * 64 + (DIGITS_PER_ROW - 1 - col) * 4) +: 4];
        line = GLYPH[nib][3'(cy)];
        if (line[3'(4 - cx)])
            return (col % 2 == 1) ? FG_ODD : FG_EVEN;
        return BG;
    endfunction

    task automatic close_test();
        if (test_errs == 0)
        begin
            $display("PASS %s", test_name);
            pass_cnt++;
        end
        else
        begin
            $display("FAIL %s (%0d errors)", test_name, test_errs);
            fail_cnt++;
        end
        test_open = 1'b0;
    endtask

    task automatic open_test(input string name);
        if (test_open)
            close_test();
        test_name = name;
        test_errs = 0;
        test_open = 1'b1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        test_errs++;
        err_total++;
    endtask

    task automatic note_problem(input string msg);
        $display("ERROR: %s", msg);
        test_errs++;
        err_total++;
    endtask

    task automatic check_idle_pins(input string when);
        if (oled_csn !== 1'b1)
            report_mismatch({"oled_csn ", when}, 32'(oled_csn), 32'h1);
        if (oled_clk !== 1'b0)
            report_mismatch({"oled_clk ", when}, 32'(oled_clk), 32'h0);
        if (oled_resn !== 1'b0)
            report_mismatch({"oled_resn ", when}, 32'(oled_resn), 32'h0);
        if (oled_mosi !== 1'b0)
            report_mismatch({"oled_mosi ", when}, 32'(oled_mosi), 32'h0);
        if (oled_dc !== 1'b0)
            report_mismatch({"oled_dc ", when}, 32'(oled_dc), 32'h0);
    endtask

    task automatic check_init_length();
        if (!init_done)
        begin
            if (init_seen != INIT_LEN)
                report_mismatch("init byte count", 32'(init_seen), 32'(INIT_LEN));
            init_done = 1'b1;
        end
    endtask

    task automatic handle_byte();
        logic [7:0] expected;
        int         x;
        int         y;
        if (byte_init)
            init_seen++;
        else if (!byte_dc)
        begin
            if (byte_idx == 0)
            begin
                check_init_length();
                if (pix_open)
                begin
                    note_problem($sformatf("frame %0d ended after %0d pixel bytes",
                                           frame_num, pix_seen));
                    pix_open = 1'b0;
                end
                frame_num++;
                rec_btn  = btn; // stable since the middle of the last frame.
                exp_word = build_word(frame_num, rec_btn);
                win_seen = 0;
                open_test($sformatf("frame %0d window", frame_num));
            end
            if (byte_idx < 6)
            begin
                if (byte_data != WIN_CMDS[3'(byte_idx)])
                    report_mismatch($sformatf("oled_mosi window byte %0d", byte_idx),
                                    32'(byte_data), 32'(WIN_CMDS[3'(byte_idx)]));
            end
            else
                note_problem($sformatf("frame %0d has more than six window bytes", frame_num));
            win_seen++;
        end
        else
        begin
            if (byte_idx == 0)
            begin
                check_init_length();
                if (win_seen != 6)
                    note_problem($sformatf("frame %0d had %0d window bytes before its pixels",
                                           frame_num, win_seen));
                open_test($sformatf("frame %0d pixels, buttons 0x%02h", frame_num, rec_btn));
                pix_open = 1'b1;
                pix_seen = 0;
            end
            x = byte_idx % PANEL_W;
            y = byte_idx / PANEL_W;
            if (byte_idx >= PIXELS)
                note_problem($sformatf("frame %0d sent more than %0d pixel bytes",
                                       frame_num, PIXELS));
            else
            begin
                expected = expect_color(x, y, exp_word);
                if (byte_data != expected)
                    report_mismatch($sformatf("oled_mosi pixel (%0d,%0d) of frame %0d",
                                              x, y, frame_num),
                                    32'(byte_data), 32'(expected));
            end
            pix_seen++;
            if (byte_idx == BTN_PIXEL - 1)
                btn_due = 1'b1;
            if (byte_idx == PIXELS - 1)
            begin
                close_test();
                pix_open = 1'b0;
                frames_done++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hb96e));
        rst_n    = 1'b0;
        btn      = 7'($urandom());
        open_test("reset state");
        repeat (5)
        begin
            @(posedge clk);
            #10;
            check_idle_pins("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_pins("after reset");
        while (oled_resn === 1'b0)
        begin
            low_cycles++;
            @(negedge clk);
        end
        if (low_cycles != RESET_LOW_CYCLES)
            report_mismatch("oled_resn low cycles", 32'(low_cycles), 32'(RESET_LOW_CYCLES));

        open_test("init stream");
        while (frames_done < FRAMES)
        begin
            @(posedge clk);
            if (byte_stb)
                handle_byte();
            #10;
            if (btn_due)
            begin
                btn     = 7'($urandom()); // shown from the next frame on.
                btn_due = 1'b0;
            end
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_cnt, fail_cnt, err_total);
        if (err_total == 0 && fail_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: project.f
logic/oled_pkg.sv
logic/hex_pkg.sv
logic/oled_init_rom.sv
logic/spi_byte_tx.sv
logic/hex_renderer.sv
logic/oled_controller.sv
logic/hex_display_top.sv
bench/oled_panel_model.sv
bench/tb_hex_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_hex_display -o sim_tb_hex_display
./obj_dir/sim_tb_hex_display | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1
